// File: src/cordicPkg.sv
package cordicPkg;

	// Sample widths on the input side and inside the CORDIC datapath
	localparam int sampleWidth = 16;
	// Two guard bits absorb the CORDIC gain and the quadrant fold
	localparam int cordicWidth = 18;

	// A full turn of phase spans 2**phaseWidth units
	localparam int phaseWidth = 16;

	// Stage k shifts by k
	localparam int numStages = 14;

	// Arctangent of 2**-k, scaled so that a full turn is 65536
	localparam logic [phaseWidth-1:0] atanTable [numStages] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651,  16'd326,  16'd163,  16'd81,
		16'd41,   16'd20,   16'd10,   16'd5,
		16'd3,    16'd1
	};

	// The input FIFO depth is also the credit the upstream sender starts with
	localparam int inFifoDepth = 8;
	localparam int inPtrWidth = $clog2(inFifoDepth);
	localparam int inCountWidth = $clog2(inFifoDepth + 1);

	// Must cover every sample in the rotator plus some slack for the sink
	localparam int outFifoDepth = 16;
	localparam int outPtrWidth = $clog2(outFifoDepth);
	localparam int outCountWidth = $clog2(outFifoDepth + 1);

	// Credits the DUT holds toward the sink after reset
	localparam int sinkCredits = 4;
	localparam int sinkCountWidth = $clog2(sinkCredits + 1);

	// In-band opcodes of the input stream
	typedef enum logic [1:0] {
		OP_DATA      = 2'd0,
		OP_SET_FREQ  = 2'd1,
		OP_SET_PHASE = 2'd2
	} mixOp_t;

	// For set opcodes the i field carries the new value
	typedef struct packed {
		mixOp_t                 op;
		logic [sampleWidth-1:0] i;
		logic [sampleWidth-1:0] q;
	} mixWord_t;

	// Working state of one CORDIC pipeline slot
	typedef struct packed {
		logic [cordicWidth-1:0] i;
		logic [cordicWidth-1:0] q;
		logic [phaseWidth-1:0]  phase;
	} cordicState_t;

	typedef struct packed {
		logic [cordicWidth-1:0] i;
		logic [cordicWidth-1:0] q;
	} iqResult_t;

endpackage

// File: src/cordicStage.sv
`timescale 1ns/1ps

module cordicStage #(
	parameter int shift = 0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    inValid,
	input  cordicPkg::cordicState_t stateIn,
	output logic                    outValid,
	output cordicPkg::cordicState_t stateOut
);
	import cordicPkg::*;

	logic signed [cordicWidth-1:0] iShifted;
	logic signed [cordicWidth-1:0] qShifted;
	logic                          phaseNonNeg;

	// Arithmetic shifts keep the sign of the operand
	assign iShifted = $signed(stateIn.i) >>> shift;
	assign qShifted = $signed(stateIn.q) >>> shift;

	// The residual phase is read as a two's complement angle
	assign phaseNonNeg = ~stateIn.phase[phaseWidth-1];

	// Only the valid bit is control state
	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	// Rotate toward zero residual, by plus or minus atan(2**-shift)
	always_ff @(posedge clk)
	begin
		if (phaseNonNeg)
		begin
			stateOut.i     <= stateIn.i - qShifted;
			stateOut.q     <= stateIn.q + iShifted;
			stateOut.phase <= stateIn.phase - atanTable[shift];
		end
		else
		begin
			stateOut.i     <= stateIn.i + qShifted;
			stateOut.q     <= stateIn.q - iShifted;
			stateOut.phase <= stateIn.phase + atanTable[shift];
		end
	end

endmodule

// File: src/cordicRotator.sv
`timescale 1ns/1ps

module cordicRotator (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    inValid,
	input  cordicPkg::cordicState_t stateIn,
	output logic                    resValid,
	output cordicPkg::iqResult_t    result
);
	import cordicPkg::*;

	// Slot 0 is the pre-rotation register, slot k+1 the output of stage k
	cordicState_t stageState [numStages+1];
	logic         stageValid [numStages+1];
	logic         quadFold;

	// The two top phase bits differ when the angle is beyond a quarter turn
	assign quadFold = stateIn.phase[phaseWidth-1] ^ stateIn.phase[phaseWidth-2];

	always_ff @(posedge clk)
	begin
		if (reset)
			stageValid[0] <= 1'b0;
		else
			stageValid[0] <= inValid;
	end

	// Fold the angle into the convergence range of the stage chain
	always_ff @(posedge clk)
	begin
		if (quadFold)
		begin
			// A half-turn rotation negates both components
			stageState[0].i <= -stateIn.i;
			stageState[0].q <= -stateIn.q;
			// Adding half a turn only flips the top phase bit
			stageState[0].phase <= {~stateIn.phase[phaseWidth-1],
				stateIn.phase[phaseWidth-2:0]};
		end
		else
		begin
			stageState[0] <= stateIn;
		end
	end

	// One micro-rotation per stage, each with its own shift
	for (genvar k = 0; k < numStages; k++)
	begin : stageGen
		cordicStage #(
			.shift(k)
		) i_cordicStage (
			.clk     (clk),
			.reset   (reset),
			.inValid (stageValid[k]),
			.stateIn (stageState[k]),
			.outValid(stageValid[k+1]),
			.stateOut(stageState[k+1])
		);
	end

	// The residual phase of the last stage is dropped
	assign resValid = stageValid[numStages];
	assign result = '{i: stageState[numStages].i, q: stageState[numStages].q};

endmodule

// File: src/phaseAccumulator.sv
`timescale 1ns/1ps

module phaseAccumulator (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           cfgValid,
	input  cordicPkg::mixOp_t              cfgOp,
	input  logic [cordicPkg::phaseWidth-1:0] cfgValue,
	input  logic                           advance,
	output logic [cordicPkg::phaseWidth-1:0] curPhase
);
	import cordicPkg::*;

	logic [phaseWidth-1:0] freq;
	logic [phaseWidth-1:0] phase;

	// The sample launched this cycle takes the phase before the step
	assign curPhase = phase;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			freq  <= '0;
			phase <= '0;
		end
		else if (cfgValid)
		begin
			// Only one word leaves ingress per cycle, so no launch competes here
			case (cfgOp)
				OP_SET_FREQ:
				begin
					freq <= cfgValue;
				end
				OP_SET_PHASE:
				begin
					phase <= cfgValue;
				end
				default:
				begin
					// Unknown config opcodes leave the oscillator as is
					freq <= freq;
				end
			endcase
		end
		else if (advance)
		begin
			// Wraps modulo a full turn by the register width
			phase <= phase + freq;
		end
	end

endmodule

// File: src/creditIngress.sv
`timescale 1ns/1ps

module creditIngress (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           inValid,
	input  cordicPkg::mixWord_t            inWord,
	output logic                           inCredit,
	input  logic                           slotFree,
	output logic                           launchValid,
	output cordicPkg::iqResult_t           launchSample,
	output logic                           cfgValid,
	output cordicPkg::mixOp_t              cfgOp,
	output logic [cordicPkg::phaseWidth-1:0] cfgValue
);
	import cordicPkg::*;

	mixWord_t                mem [inFifoDepth];
	logic [inPtrWidth-1:0]   wrPtr;
	logic [inPtrWidth-1:0]   rdPtr;
	logic [inCountWidth-1:0] count;
	mixWord_t                headWord;
	logic                    notEmpty;
	logic                    headIsData;
	logic                    pop;

	assign headWord = mem[rdPtr];
	assign notEmpty = count != '0;
	assign headIsData = headWord.op == OP_DATA;

	// Data waits for an output slot, config words go straight through
	assign launchValid = notEmpty && headIsData && slotFree;
	assign cfgValid = notEmpty && !headIsData;
	assign pop = launchValid || cfgValid;

	// Every word that leaves the FIFO hands one credit back upstream
	assign inCredit = pop;

	assign cfgOp = headWord.op;
	assign cfgValue = headWord.i;

	// Widen the sample into the guard-bit format of the rotator
	assign launchSample = '{
		i: {{(cordicWidth-sampleWidth){headWord.i[sampleWidth-1]}}, headWord.i},
		q: {{(cordicWidth-sampleWidth){headWord.q[sampleWidth-1]}}, headWord.q}
	};

	// The sender only writes while it holds a credit, so there is always room
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			mem[wrPtr] <= inWord;
		end
	end

	// Depth is a power of two, so the pointers wrap on their own
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (inValid)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + inCountWidth'(inValid) - inCountWidth'(pop);
		end
	end

endmodule

// File: src/creditEgress.sv
`timescale 1ns/1ps

module creditEgress (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 reserve,
	input  logic                 resValid,
	input  cordicPkg::iqResult_t result,
	output logic                 slotFree,
	output logic                 outValid,
	output cordicPkg::iqResult_t outResult,
	input  logic                 outCredit
);
	import cordicPkg::*;

	iqResult_t                mem [outFifoDepth];
	logic [outPtrWidth-1:0]   wrPtr;
	logic [outPtrWidth-1:0]   rdPtr;
	logic [outCountWidth-1:0] fifoCount;
	logic [outCountWidth-1:0] reservedCount;
	logic [sinkCountWidth-1:0] sinkCount;
	logic                     send;

	// The head leaves whenever one is stored and the sink has room for it
	assign send = (fifoCount != '0) && (sinkCount != '0);
	assign outValid = send;
	assign outResult = mem[rdPtr];

	// Reserved slots cover stored results and samples still in the rotator
	assign slotFree = reservedCount < outCountWidth'(outFifoDepth);

	// A reserved slot guarantees room for every arriving result
	always_ff @(posedge clk)
	begin
		if (resValid)
		begin
			mem[wrPtr] <= result;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr         <= '0;
			rdPtr         <= '0;
			fifoCount     <= '0;
			reservedCount <= '0;
			sinkCount     <= sinkCountWidth'(sinkCredits);
		end
		else
		begin
			if (resValid)
				wrPtr <= wrPtr + 1'b1;
			if (send)
				rdPtr <= rdPtr + 1'b1;
			fifoCount <= fifoCount + outCountWidth'(resValid) - outCountWidth'(send);
			// A slot is held from launch until its result is sent
			reservedCount <= reservedCount + outCountWidth'(reserve)
				- outCountWidth'(send);
			// A returned credit and a send in one cycle cancel out
			sinkCount <= sinkCount + sinkCountWidth'(outCredit)
				- sinkCountWidth'(send);
		end
	end

endmodule

// File: src/cordicMixer.sv
`timescale 1ns/1ps

module cordicMixer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 inValid,
	input  cordicPkg::mixWord_t  inWord,
	output logic                 inCredit,
	output logic                 outValid,
	output cordicPkg::iqResult_t outResult,
	input  logic                 outCredit
);
	import cordicPkg::*;

	logic                  slotFree;
	logic                  launchValid;
	iqResult_t             launchSample;
	logic                  cfgValid;
	mixOp_t                cfgOp;
	logic [phaseWidth-1:0] cfgValue;
	logic [phaseWidth-1:0] curPhase;
	cordicState_t          rotState;
	logic                  resValid;
	iqResult_t             rotResult;

	// Input side pops words, applies config and launches data
	creditIngress i_creditIngress (
		.clk         (clk),
		.reset       (reset),
		.inValid     (inValid),
		.inWord      (inWord),
		.inCredit    (inCredit),
		.slotFree    (slotFree),
		.launchValid (launchValid),
		.launchSample(launchSample),
		.cfgValid    (cfgValid),
		.cfgOp       (cfgOp),
		.cfgValue    (cfgValue)
	);

	// Each launch takes the current phase and steps the oscillator once
	phaseAccumulator i_phaseAccumulator (
		.clk     (clk),
		.reset   (reset),
		.cfgValid(cfgValid),
		.cfgOp   (cfgOp),
		.cfgValue(cfgValue),
		.advance (launchValid),
		.curPhase(curPhase)
	);

	// The rotator starts from the widened sample and the oscillator phase
	assign rotState = '{i: launchSample.i, q: launchSample.q, phase: curPhase};

	cordicRotator i_cordicRotator (
		.clk     (clk),
		.reset   (reset),
		.inValid (launchValid),
		.stateIn (rotState),
		.resValid(resValid),
		.result  (rotResult)
	);

	// The launch pulse also reserves the output slot for its result
	creditEgress i_creditEgress (
		.clk      (clk),
		.reset    (reset),
		.reserve  (launchValid),
		.resValid (resValid),
		.result   (rotResult),
		.slotFree (slotFree),
		.outValid (outValid),
		.outResult(outResult),
		.outCredit(outCredit)
	);

endmodule

// File: testbench/mixerModel.svh
`ifndef MIXER_MODEL_SVH
`define MIXER_MODEL_SVH

// Expected results in launch order, which is also the order they leave the DUT
iqResult_t expQ [$];

// Private copy of the oscillator, stepped only by data words
logic [phaseWidth-1:0] modelFreq = '0;
logic [phaseWidth-1:0] modelPhase = '0;

// Arctangent of 2**-k in phase units, where a full turn is 2**phaseWidth
function automatic logic [phaseWidth-1:0] atanUnits(input int k);
	real pi;
	real turn;
	real angle;
	pi = 4.0 * $atan(1.0);
	turn = 2.0 ** phaseWidth;
	angle = $atan(1.0 / (2.0 ** k));
	// Rounded to the nearest unit
	return phaseWidth'($rtoi(angle * turn / (2.0 * pi) + 0.5));
endfunction

// Rotation of one sample by one phase, bit for bit as the pipeline does it
function automatic iqResult_t cordicReference(input logic [sampleWidth-1:0] sampI,
	input logic [sampleWidth-1:0] sampQ, input logic [phaseWidth-1:0] startPhase);
	logic signed [cordicWidth-1:0] x;
	logic signed [cordicWidth-1:0] y;
	logic signed [cordicWidth-1:0] xNext;
	logic [phaseWidth-1:0]         z;
	x = cordicWidth'($signed(sampI));
	y = cordicWidth'($signed(sampQ));
	z = startPhase;
	// Beyond a quarter turn either way the sample is turned by half a turn first
	if (z[phaseWidth-1] != z[phaseWidth-2])
	begin
		x = -x;
		y = -y;
		z = z + phaseWidth'(1 << (phaseWidth - 1));
	end
	for (int k = 0; k < numStages; k++)
	begin
		// The sign of the residual angle picks the direction of each micro-rotation
		if (!z[phaseWidth-1])
		begin
			xNext = x - (y >>> k);
			y = y + (x >>> k);
			z = z - atanUnits(k);
		end
		else
		begin
			xNext = x + (y >>> k);
			y = y - (x >>> k);
			z = z + atanUnits(k);
		end
		x = xNext;
	end
	return '{i: x, q: y};
endfunction

// Applies one sent word to the model, in the same order the DUT pops it
task automatic modelWord(input mixWord_t w);
	case (w.op)
		OP_SET_FREQ:
		begin
			modelFreq = w.i;
		end
		OP_SET_PHASE:
		begin
			modelPhase = w.i;
		end
		default:
		begin
			// Data takes the phase before the step
			expQ.push_back(cordicReference(w.i, w.q, modelPhase));
			modelPhase = modelPhase + modelFreq;
		end
	endcase
endtask

function automatic iqResult_t popExpected();
	return expQ.pop_front();
endfunction

`endif

// File: testbench/tbCordicMixer.sv
`timescale 1ns/1ps

module tbCordicMixer;
	import cordicPkg::*;

	`include "mixerModel.svh"

	logic      clk = 1'b0;
	logic      reset = 1'b1;
	logic      inValid = 1'b0;
	mixWord_t  inWord = '0;
	logic      inCredit;
	logic      outValid;
	iqResult_t outResult;
	logic      outCredit = 1'b0;

	// Sender credits, the mirror of the DUT's sink credits, and run bookkeeping
	int        creditCount = inFifoDepth;
	int        sinkHeld = sinkCredits;
	int        creditPulses = 0;
	int        wordsSent = 0;
	int        cycleNum = 0;
	int        watchdogCycles = 0;
	int        stallStart = 0;
	int        returnQ [$];
	bit        holdCredits = 1'b0;
	iqResult_t expectedResult;

	cordicMixer i_cordicMixer (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inWord   (inWord),
		.inCredit (inCredit),
		.outValid (outValid),
		.outResult(outResult),
		.outCredit(outCredit)
	);

	always #10 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string sigName, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, sigName, got,
				expected);
			failRun("A compared value did not match");
		end
	endtask

	// Called at 2 ns after an edge, returns at 2 ns after a later edge
	task automatic sendWord(input mixWord_t w);
		while (creditCount == 0)
		begin
			@(posedge clk);
			#2;
		end
		inValid = 1'b1;
		inWord = w;
		modelWord(w);
		wordsSent++;
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	task automatic sendSample();
		sendWord('{op: OP_DATA, i: 16'($urandom), q: 16'($urandom)});
	endtask

	task automatic sendSetting(input mixOp_t op, input logic [phaseWidth-1:0] value);
		sendWord('{op: op, i: value, q: '0});
	endtask

	// Waits until every expected result has come out, with a bound
	task automatic waitDrained();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < 3000)
		begin
			@(posedge clk);
			waited++;
		end
		repeat (10) @(posedge clk);
		#2;
	endtask

	// Counts sender credits, and no pulse may ever exceed the starting amount
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (inCredit)
				creditPulses++;
			creditCount = creditCount + int'(inCredit) - int'(inValid);
			if (creditCount > inFifoDepth)
				failRun("The DUT returned more input credits than the sender ever held");
		end
	end

	// Comparator, which also tracks the sink credits the DUT should still hold
	always @(posedge clk)
	begin
		cycleNum++;
		if (!reset)
		begin
			if (outValid && sinkHeld == 0)
				failRun("outValid seen while the DUT holds no sink credit");
			else if (outValid && expQ.size() == 0)
				failRun("outValid seen with no expected result pending");
			else if (outValid)
			begin
				expectedResult = popExpected();
				checkValue("outResult", 64'(outResult), 64'(expectedResult));
				// Each consumed result is handed back 0 to 5 cycles later
				returnQ.push_back(cycleNum + int'($urandom_range(0, 5)));
			end
			sinkHeld = sinkHeld + int'(outCredit) - int'(outValid);
		end
	end

	// Sink credit return, at most one pulse per cycle
	always @(posedge clk)
	begin
		#2;
		if (!holdCredits && returnQ.size() != 0 && returnQ[0] <= cycleNum)
		begin
			outCredit = 1'b1;
			void'(returnQ.pop_front());
		end
		else
			outCredit = 1'b0;
	end

	// Budget grows with the words sent, so a stuck driver or sink ends the run
	always @(posedge clk)
	begin
		watchdogCycles++;
		if (watchdogCycles > wordsSent * 40 + 2000)
			failRun("Timeout: the run took longer than its word count allows");
	end

	initial
	begin
		void'($urandom(13));
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		// Zero frequency and zero phase leave only the CORDIC gain
		repeat (10) sendSample();
		waitDrained();

		// Each quadrant, one unit either side of its border, and its middle
		for (int quad = 0; quad < 4; quad++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				sendSetting(OP_SET_PHASE,
					phaseWidth'(quad * 16384 + ((j == 3) ? 8192 : j - 1)));
				repeat (3) sendSample();
			end
		end
		waitDrained();

		// Set words mixed between data must not step the oscillator
		sendSetting(OP_SET_FREQ, 16'h0123);
		for (int n = 0; n < 24; n++)
		begin
			sendSample();
			if (n % 5 == 4)
				sendSetting(OP_SET_FREQ, 16'($urandom));
			if (n % 7 == 6)
				sendSetting(OP_SET_PHASE, 16'($urandom));
		end
		waitDrained();

		// Sink stalls for 200 cycles while the sender keeps pushing
		holdCredits = 1'b1;
		fork
			begin
				repeat (40) sendSample();
			end
			begin
				repeat (100) @(posedge clk);
				#2;
				stallStart = creditPulses;
				repeat (100) @(posedge clk);
				#2;
				checkValue("inCredit pulses while stalled", 64'(creditPulses - stallStart),
					64'(0));
				holdCredits = 1'b0;
			end
		join
		waitDrained();

		// Long random mix of data and set words
		for (int n = 0; n < 500; n++)
		begin
			case (int'($urandom_range(0, 9)))
				0: sendSetting(OP_SET_FREQ, 16'($urandom));
				1: sendSetting(OP_SET_PHASE, 16'($urandom));
				default: sendSample();
			endcase
		end
		waitDrained();

		checkValue("inCredit pulse total", 64'(creditPulses), 64'(wordsSent));
		if (expQ.size() != 0)
			failRun("Expected results were still pending at the end of the run");
		else
		begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

// File: filelist.f
+incdir+testbench
src/cordicPkg.sv
src/cordicStage.sv
src/cordicRotator.sv
src/phaseAccumulator.sv
src/creditIngress.sv
src/creditEgress.sv
src/cordicMixer.sv
testbench/tbCordicMixer.sv

// File: Makefile
# Verilator build and run of the CORDIC mixer testbench

TOP = tbCordicMixer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f

# A $fatal in the testbench gives a nonzero exit status, which fails this target
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
